// ==== run.sh ====
#!/bin/sh
# Build the BTAC testbench with Verilator, run it, and judge the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f tb.f --top-module btac_tb -o btac_sim \
  && ./obj_dir/btac_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log && echo "RUN PASSED" || { echo "RUN FAILED"; exit 1; }

// ==== source/bht_counters.sv ====
`timescale 1ns/1ps

module bht_counters #(
  parameter int bht_entries = btac_config_pkg::default_bht_entries
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [$clog2(bht_entries)-1:0]   raddr,
  input  logic [$clog2(bht_entries)-1:0]   waddr,
  input  logic                             wen,
  input  logic                             taken,
  output btac_types_pkg::counter_t         rcount
);

  import btac_types_pkg::*;

  counter_t count_mem [bht_entries];
  counter_t old_count;
  counter_t new_count;

  ////////////////////////////////////////////////////////////
  // Saturating step toward the resolved direction
  ////////////////////////////////////////////////////////////

  always_comb begin
    old_count = count_mem[waddr];
    new_count = old_count;
    if (taken) begin
      if (old_count != 2'd3) begin
        new_count = old_count + 2'd1;
      end
    end else begin
      if (old_count != 2'd0) begin
        new_count = old_count - 2'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < bht_entries; i++) begin
        count_mem[i] <= counter_init;
      end
    end else if (wen) begin
      count_mem[waddr] <= new_count;
    end
  end

  assign rcount = count_mem[raddr];  // Prediction read

endmodule

// ==== source/btac.sv ====
`timescale 1ns/1ps

module btac #(
  parameter int btb_entries = btac_config_pkg::default_btb_entries,
  parameter int bht_entries = btac_config_pkg::default_bht_entries
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  get_valid,
  input  btac_types_pkg::pc_t   get_pc,
  input  logic                  clear,
  input  logic                  upd_valid,
  input  btac_types_pkg::pc_t   upd_pc,
  input  logic                  upd_taken,
  input  btac_types_pkg::pc_t   upd_target,
  input  logic                  upd_pred_taken,
  input  btac_types_pkg::pc_t   upd_pred_target,
  output logic                  pred_valid,
  output logic                  pred_taken,
  output btac_types_pkg::pc_t   pred_target,
  output logic                  pred_miss,
  output btac_types_pkg::pc_t   pred_maddr
);

  import btac_types_pkg::*;

  logic [$clog2(btb_entries)-1:0] btb_raddr;
  logic [$clog2(btb_entries)-1:0] btb_waddr;
  logic                           btb_wen;
  btb_entry_t                     btb_wentry;
  btb_entry_t                     btb_rentry;
  logic [$clog2(bht_entries)-1:0] bht_raddr;
  logic [$clog2(bht_entries)-1:0] bht_waddr;
  logic                           bht_wen;
  logic                           bht_taken;
  counter_t                       bht_rcount;

  btb_memory #(
    .btb_entries (btb_entries)
  ) btb_i (
    .clock  (clock),
    .reset  (reset),
    .raddr  (btb_raddr),
    .waddr  (btb_waddr),
    .wen    (btb_wen),
    .wentry (btb_wentry),
    .rentry (btb_rentry)
  );

  bht_counters #(
    .bht_entries (bht_entries)
  ) bht_i (
    .clock  (clock),
    .reset  (reset),
    .raddr  (bht_raddr),
    .waddr  (bht_waddr),
    .wen    (bht_wen),
    .taken  (bht_taken),
    .rcount (bht_rcount)
  );

  btac_ctrl #(
    .btb_entries (btb_entries),
    .bht_entries (bht_entries)
  ) ctrl_i (
    .clock           (clock),
    .reset           (reset),
    .get_valid       (get_valid),
    .get_pc          (get_pc),
    .clear           (clear),
    .upd_valid       (upd_valid),
    .upd_pc          (upd_pc),
    .upd_taken       (upd_taken),
    .upd_target      (upd_target),
    .upd_pred_taken  (upd_pred_taken),
    .upd_pred_target (upd_pred_target),
    .btb_rentry      (btb_rentry),
    .bht_rcount      (bht_rcount),
    .pred_valid      (pred_valid),
    .pred_taken      (pred_taken),
    .pred_target     (pred_target),
    .pred_miss       (pred_miss),
    .pred_maddr      (pred_maddr),
    .btb_raddr       (btb_raddr),
    .btb_waddr       (btb_waddr),
    .btb_wen         (btb_wen),
    .btb_wentry      (btb_wentry),
    .bht_raddr       (bht_raddr),
    .bht_waddr       (bht_waddr),
    .bht_wen         (bht_wen),
    .bht_taken       (bht_taken)
  );

endmodule

// ==== source/btac_config_pkg.sv ====
package btac_config_pkg;

  ////////////////////////////////////////////////////////////
  // Fetch unit geometry
  ////////////////////////////////////////////////////////////

  localparam int pc_width = 32;  // Instruction address width

  // Fall-through increment of a 32-bit instruction
  localparam int inst_step = 4;

  ////////////////////////////////////////////////////////////
  // Table depths as powers of two
  ////////////////////////////////////////////////////////////

  localparam int default_btb_entries = 16;
  localparam int default_bht_entries = 64;

endpackage

// ==== source/btac_ctrl.sv ====
`timescale 1ns/1ps

module btac_ctrl #(
  parameter int btb_entries = btac_config_pkg::default_btb_entries,
  parameter int bht_entries = btac_config_pkg::default_bht_entries
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             get_valid,
  input  btac_types_pkg::pc_t              get_pc,
  input  logic                             clear,
  input  logic                             upd_valid,
  input  btac_types_pkg::pc_t              upd_pc,
  input  logic                             upd_taken,
  input  btac_types_pkg::pc_t              upd_target,
  input  logic                             upd_pred_taken,
  input  btac_types_pkg::pc_t              upd_pred_target,
  input  btac_types_pkg::btb_entry_t       btb_rentry,
  input  btac_types_pkg::counter_t         bht_rcount,
  output logic                             pred_valid,
  output logic                             pred_taken,
  output btac_types_pkg::pc_t              pred_target,
  output logic                             pred_miss,
  output btac_types_pkg::pc_t              pred_maddr,
  output logic [$clog2(btb_entries)-1:0]   btb_raddr,
  output logic [$clog2(btb_entries)-1:0]   btb_waddr,
  output logic                             btb_wen,
  output btac_types_pkg::btb_entry_t       btb_wentry,
  output logic [$clog2(bht_entries)-1:0]   bht_raddr,
  output logic [$clog2(bht_entries)-1:0]   bht_waddr,
  output logic                             bht_wen,
  output logic                             bht_taken
);

  import btac_config_pkg::*;
  import btac_types_pkg::*;

  localparam int btb_idx_width = $clog2(btb_entries);
  localparam int bht_idx_width = $clog2(bht_entries);

  pc_t  lookup_pc;
  logic lookup_valid;
  logic entry_hit;
  pc_t  upd_fall;
  pc_t  correct_addr;
  pc_t  guessed_addr;

  ////////////////////////////////////////////////////////////
  // Lookup register and prediction
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      lookup_pc    <= '0;
      lookup_valid <= 1'b0;
    end else begin
      lookup_valid <= get_valid & ~clear;
      if (get_valid && !clear) begin
        lookup_pc <= get_pc;
      end
    end
  end

  // Index from PC bit 1 upward
  assign btb_raddr = lookup_pc[btb_idx_width:1];
  assign bht_raddr = lookup_pc[bht_idx_width:1];

  assign entry_hit   = btb_rentry.valid && (btb_rentry.tag == lookup_pc);
  assign pred_valid  = lookup_valid;
  assign pred_taken  = lookup_valid & entry_hit & bht_rcount[1];  // Counter 2 or 3
  assign pred_target = pred_taken ? btb_rentry.target : lookup_pc + pc_t'(inst_step);

  ////////////////////////////////////////////////////////////
  // Table writes
  ////////////////////////////////////////////////////////////

  assign bht_wen   = upd_valid & ~clear;
  assign bht_waddr = upd_pc[bht_idx_width:1];
  assign bht_taken = upd_taken;

  // Only taken branches install a target
  assign btb_wen           = upd_valid & upd_taken & ~clear;
  assign btb_waddr         = upd_pc[btb_idx_width:1];
  assign btb_wentry.valid  = 1'b1;
  assign btb_wentry.tag    = upd_pc;
  assign btb_wentry.target = upd_target;

  ////////////////////////////////////////////////////////////
  // Resolve
  ////////////////////////////////////////////////////////////

  assign upd_fall     = upd_pc + pc_t'(inst_step);
  assign correct_addr = upd_taken ? upd_target : upd_fall;
  assign guessed_addr = upd_pred_taken ? upd_pred_target : upd_fall;

  assign pred_miss  = upd_valid & ~clear & (correct_addr != guessed_addr);
  assign pred_maddr = pred_miss ? correct_addr : '0;  // Redirect address

endmodule

// ==== source/btac_types_pkg.sv ====
package btac_types_pkg;

  import btac_config_pkg::*;

  typedef logic [pc_width-1:0] pc_t;

  // One BTB line whose tag holds the whole branch PC
  typedef struct packed {
    logic valid;
    pc_t  tag;
    pc_t  target;
  } btb_entry_t;

  // Counter values 0 and 1 say not taken, 2 and 3 say taken
  typedef logic [1:0] counter_t;

  localparam counter_t counter_init = 2'd1;  // Weakly not taken

endpackage

// ==== source/btb_memory.sv ====
`timescale 1ns/1ps

module btb_memory #(
  parameter int btb_entries = btac_config_pkg::default_btb_entries
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [$clog2(btb_entries)-1:0]   raddr,
  input  logic [$clog2(btb_entries)-1:0]   waddr,
  input  logic                             wen,
  input  btac_types_pkg::btb_entry_t       wentry,
  output btac_types_pkg::btb_entry_t       rentry
);

  import btac_types_pkg::*;

  logic valid_mem  [btb_entries];
  pc_t  tag_mem    [btb_entries];
  pc_t  target_mem [btb_entries];

  // Valid bits
  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < btb_entries; i++) begin
        valid_mem[i] <= 1'b0;
      end
    end else if (wen) begin
      valid_mem[waddr] <= wentry.valid;
    end
  end

  // Tag and target payload
  always_ff @(posedge clock) begin
    if (wen) begin
      tag_mem[waddr]    <= wentry.tag;
      target_mem[waddr] <= wentry.target;
    end
  end

  always_comb begin
    rentry.valid  = valid_mem[raddr];
    rentry.tag    = tag_mem[raddr];
    rentry.target = target_mem[raddr];
  end

endmodule

// ==== tb.f ====
source/btac_config_pkg.sv
source/btac_types_pkg.sv
source/btb_memory.sv
source/bht_counters.sv
source/btac_ctrl.sv
source/btac.sv
verif/btac_properties.sv
verif/btac_tb.sv

// ==== verif/btac_properties.sv ====
`timescale 1ns/1ps

module btac_properties (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic upd_valid,
  input logic pred_valid,
  input logic pred_taken,
  input logic pred_miss
);

  // Lookup register still empty at the first edge out of reset
  reset_release_a: assert property (@(posedge clock) $rose(reset) |-> !pred_valid)
    else $error("pred_valid high right after reset release");

  taken_valid_a: assert property (@(posedge clock) disable iff (!reset)
    pred_taken |-> pred_valid)
    else $error("pred_taken without pred_valid");

  miss_source_a: assert property (@(posedge clock) disable iff (!reset)
    pred_miss |-> (upd_valid && !clear))
    else $error("pred_miss without a live update");

  clear_blocks_a: assert property (@(posedge clock) disable iff (!reset)
    clear |=> !pred_valid)
    else $error("pred_valid high in the cycle after clear");  // Flush drops the lookup

endmodule

bind btac btac_properties props_i (.*);

// ==== verif/btac_tb.sv ====
`timescale 1ns/1ps

module btac_tb;

  import btac_config_pkg::*;
  import btac_types_pkg::*;

  localparam int clock_period = 100;
  localparam int reset_cycles = 16;
  localparam int max_rows = 64;
  localparam int random_rows = 40;
  localparam int btb_bits = $clog2(default_btb_entries);
  localparam int bht_bits = $clog2(default_bht_entries);

  localparam pc_t step  = pc_t'(inst_step);
  localparam pc_t pc_a  = 32'h0000_1000;
  localparam pc_t tgt_a = 32'h0000_1400;
  localparam pc_t pc_b  = 32'h0000_1080;  // Same BTB and BHT index as pc_a
  localparam pc_t pc_c  = 32'h0000_1106;
  localparam pc_t tgt_c = 32'h0000_1500;
  localparam pc_t bad_c = 32'h0000_1600;
  localparam pc_t pc_d  = 32'h0000_2010;
  localparam pc_t tgt_d = 32'h0000_2400;
  localparam pc_t pc_e  = 32'h0000_300a;
  localparam pc_t tgt_e = 32'h0000_3800;

  logic clock;
  logic reset;
  logic get_valid;
  pc_t  get_pc;
  logic clear;
  logic upd_valid;
  pc_t  upd_pc;
  logic upd_taken;
  pc_t  upd_target;
  logic upd_pred_taken;
  pc_t  upd_pred_target;
  logic pred_valid;
  logic pred_taken;
  pc_t  pred_target;
  logic pred_miss;
  pc_t  pred_maddr;

  ////////////////////////////////////////////////////////////
  // Stimulus table with expected columns
  ////////////////////////////////////////////////////////////

  string row_name   [max_rows];
  logic  row_gv     [max_rows];
  pc_t   row_gpc    [max_rows];
  logic  row_clr    [max_rows];
  logic  row_uv     [max_rows];
  pc_t   row_upc    [max_rows];
  logic  row_ut     [max_rows];
  pc_t   row_utgt   [max_rows];
  logic  row_upt    [max_rows];
  pc_t   row_uptgt  [max_rows];
  logic  row_model  [max_rows];  // Expected columns come from the model
  logic  exp_valid  [max_rows];
  logic  exp_taken  [max_rows];
  pc_t   exp_target [max_rows];
  logic  exp_miss   [max_rows];
  pc_t   exp_maddr  [max_rows];

  int          num_rows = 0;
  logic        table_ready = 1'b0;
  int          watchdog_ns;
  logic [31:0] lcg_state = 32'd91069;

  btac #(
    .btb_entries (default_btb_entries),
    .bht_entries (default_bht_entries)
  ) dut_i (
    .clock           (clock),
    .reset           (reset),
    .get_valid       (get_valid),
    .get_pc          (get_pc),
    .clear           (clear),
    .upd_valid       (upd_valid),
    .upd_pc          (upd_pc),
    .upd_taken       (upd_taken),
    .upd_target      (upd_target),
    .upd_pred_taken  (upd_pred_taken),
    .upd_pred_target (upd_pred_target),
    .pred_valid      (pred_valid),
    .pred_taken      (pred_taken),
    .pred_target     (pred_target),
    .pred_miss       (pred_miss),
    .pred_maddr      (pred_maddr)
  );

  always #(clock_period / 2) clock = ~clock;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bits vary the tag only and bits 2:1 vary the index
  function automatic pc_t random_pc();
    logic [31:0] r;
    r = next_random();
    return pc_t'(32'h0000_5000) + pc_t'({r[30:29], 7'b0}) + pc_t'({r[27:26], 1'b0});
  endfunction

  function automatic pc_t random_target();
    logic [31:0] r;
    r = next_random();
    return pc_t'(32'h0000_9000) + pc_t'({r[28], 2'b0});
  endfunction

  task automatic add_row(string name, logic gv, pc_t gpc, logic clr, logic uv, pc_t upc,
                         logic ut, pc_t utgt, logic upt, pc_t uptgt);
    row_name[num_rows]  = name;
    row_gv[num_rows]    = gv;
    row_gpc[num_rows]   = gpc;
    row_clr[num_rows]   = clr;
    row_uv[num_rows]    = uv;
    row_upc[num_rows]   = upc;
    row_ut[num_rows]    = ut;
    row_utgt[num_rows]  = utgt;
    row_upt[num_rows]   = upt;
    row_uptgt[num_rows] = uptgt;
    row_model[num_rows] = 1'b0;
    num_rows++;
  endtask

  task automatic set_expected(logic pv, logic pt, pc_t ptgt, logic miss, pc_t maddr);
    exp_valid[num_rows-1]  = pv;
    exp_taken[num_rows-1]  = pt;
    exp_target[num_rows-1] = ptgt;
    exp_miss[num_rows-1]   = miss;
    exp_maddr[num_rows-1]  = maddr;
  endtask

  task automatic add_random_rows(int count);
    logic [31:0] r;
    pc_t         lookup_pc;
    pc_t         branch_pc;
    pc_t         actual_tgt;
    pc_t         guess_tgt;
    for (int i = 0; i < count; i++) begin
      r = next_random();
      lookup_pc = random_pc();
      branch_pc = random_pc();
      actual_tgt = random_target();
      guess_tgt = random_target();
      add_row($sformatf("random_%0d", i), r[31:29] != 3'd0, lookup_pc, r[28:26] == 3'd0,
              r[25], branch_pc, r[24], actual_tgt, r[23], guess_tgt);
      row_model[num_rows-1] = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model of both tables with update before lookup
  ////////////////////////////////////////////////////////////

  task automatic fill_expected();
    logic     m_valid  [default_btb_entries];
    pc_t      m_tag    [default_btb_entries];
    pc_t      m_target [default_btb_entries];
    counter_t m_count  [default_bht_entries];
    int       wi, hi, ri, rh;
    pc_t      fall, correct, guess;
    logic     miss, pv, pt;
    for (int j = 0; j < default_btb_entries; j++) begin
      m_valid[j] = 1'b0;
      m_tag[j] = '0;
      m_target[j] = '0;
    end
    for (int j = 0; j < default_bht_entries; j++) begin
      m_count[j] = counter_init;
    end
    for (int i = 0; i < num_rows; i++) begin
      wi = int'(row_upc[i][btb_bits:1]);
      hi = int'(row_upc[i][bht_bits:1]);
      if (row_uv[i] && !row_clr[i]) begin
        if (row_ut[i] && m_count[hi] != 2'd3) begin
          m_count[hi] = m_count[hi] + 2'd1;
        end else if (!row_ut[i] && m_count[hi] != 2'd0) begin
          m_count[hi] = m_count[hi] - 2'd1;
        end
        if (row_ut[i]) begin
          m_valid[wi] = 1'b1;
          m_tag[wi] = row_upc[i];
          m_target[wi] = row_utgt[i];
        end
      end
      fall = row_upc[i] + step;
      correct = row_ut[i] ? row_utgt[i] : fall;
      guess = row_upt[i] ? row_uptgt[i] : fall;
      miss = row_uv[i] && !row_clr[i] && (correct != guess);
      ri = int'(row_gpc[i][btb_bits:1]);
      rh = int'(row_gpc[i][bht_bits:1]);
      pv = row_gv[i] && !row_clr[i];
      pt = pv && m_valid[ri] && (m_tag[ri] == row_gpc[i]) && (m_count[rh] >= 2'd2);
      if (row_model[i]) begin
        exp_valid[i] = pv;
        exp_taken[i] = pt;
        exp_target[i] = pt ? m_target[ri] : row_gpc[i] + step;
        exp_miss[i] = miss;
        exp_maddr[i] = miss ? correct : '0;
      end
    end
  endtask

  task automatic build_table();
    add_row("reset_a", 1'b1, pc_a, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    set_expected(1'b1, 1'b0, pc_a + step, 1'b0, '0);
    add_row("reset_c", 1'b1, pc_c, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    set_expected(1'b1, 1'b0, pc_c + step, 1'b0, '0);
    add_row("learn_a_1", 1'b0, '0, 1'b0, 1'b1, pc_a, 1'b1, tgt_a, 1'b0, '0);
    set_expected(1'b0, 1'b0, '0, 1'b1, tgt_a);
    add_row("single_taken_a", 1'b1, pc_a, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    set_expected(1'b1, 1'b1, tgt_a, 1'b0, '0);
    add_row("learn_a_2", 1'b1, pc_a, 1'b0, 1'b1, pc_a, 1'b1, tgt_a, 1'b1, tgt_a);
    set_expected(1'b1, 1'b1, tgt_a, 1'b0, '0);
    add_row("alias_b", 1'b1, pc_b, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    set_expected(1'b1, 1'b0, pc_b + step, 1'b0, '0);
    add_row("wrong_dir", 1'b0, '0, 1'b0, 1'b1, pc_a, 1'b0, '0, 1'b1, tgt_a);
    set_expected(1'b0, 1'b0, '0, 1'b1, pc_a + step);
    add_row("wrong_tgt", 1'b0, '0, 1'b0, 1'b1, pc_c, 1'b1, tgt_c, 1'b1, bad_c);
    set_expected(1'b0, 1'b0, '0, 1'b1, tgt_c);
    add_row("sat_down_1", 1'b0, '0, 1'b0, 1'b1, pc_a, 1'b0, '0, 1'b0, '0);
    set_expected(1'b0, 1'b0, '0, 1'b0, '0);
    add_row("sat_down_2", 1'b0, '0, 1'b0, 1'b1, pc_a, 1'b0, '0, 1'b0, '0);
    set_expected(1'b0, 1'b0, '0, 1'b0, '0);
    add_row("sat_down_3", 1'b1, pc_a, 1'b0, 1'b1, pc_a, 1'b0, '0, 1'b0, '0);
    set_expected(1'b1, 1'b0, pc_a + step, 1'b0, '0);
    add_row("retrain_1", 1'b1, pc_a, 1'b0, 1'b1, pc_a, 1'b1, tgt_a, 1'b0, '0);
    set_expected(1'b1, 1'b0, pc_a + step, 1'b1, tgt_a);
    add_row("retrain_2", 1'b1, pc_a, 1'b0, 1'b1, pc_a, 1'b1, tgt_a, 1'b1, tgt_a);
    set_expected(1'b1, 1'b1, tgt_a, 1'b0, '0);
    add_row("clear_1", 1'b1, pc_d, 1'b1, 1'b1, pc_d, 1'b1, tgt_d, 1'b0, '0);
    set_expected(1'b0, 1'b0, '0, 1'b0, '0);
    add_row("clear_2", 1'b1, pc_d, 1'b1, 1'b1, pc_d, 1'b1, tgt_d, 1'b0, '0);
    set_expected(1'b0, 1'b0, '0, 1'b0, '0);
    add_row("after_clear_d", 1'b1, pc_d, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    set_expected(1'b1, 1'b0, pc_d + step, 1'b0, '0);
    add_row("same_cycle_e", 1'b1, pc_e, 1'b0, 1'b1, pc_e, 1'b1, tgt_e, 1'b0, '0);
    set_expected(1'b1, 1'b1, tgt_e, 1'b1, tgt_e);
    add_row("lookup_c", 1'b1, pc_c, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    set_expected(1'b1, 1'b1, tgt_c, 1'b0, '0);
    add_random_rows(random_rows);
    fill_expected();
    table_ready = 1'b1;
  endtask

  task automatic drive_row(int i);
    get_valid = row_gv[i];
    get_pc = row_gpc[i];
    clear = row_clr[i];
    upd_valid = row_uv[i];
    upd_pc = row_upc[i];
    upd_taken = row_ut[i];
    upd_target = row_utgt[i];
    upd_pred_taken = row_upt[i];
    upd_pred_target = row_uptgt[i];
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %b actual %b", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "Stopped at the first wrong value");
    end
  endtask

  task automatic check_pc(string name, pc_t expected, pc_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "Stopped at the first wrong value");
    end
  endtask

  task automatic check_prediction(int i);
    check_bit($sformatf("%s pred_valid", row_name[i]), exp_valid[i], pred_valid);
    check_bit($sformatf("%s pred_taken", row_name[i]), exp_taken[i], pred_taken);
    if (exp_valid[i]) begin
      check_pc($sformatf("%s pred_target", row_name[i]), exp_target[i], pred_target);
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    get_valid = 1'b0;
    get_pc = '0;
    clear = 1'b0;
    upd_valid = 1'b0;
    upd_pc = '0;
    upd_taken = 1'b0;
    upd_target = '0;
    upd_pred_taken = 1'b0;
    upd_pred_target = '0;
    build_table();
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b1;
    for (int i = 0; i < num_rows; i++) begin
      @(negedge clock);
      if (i > 0) begin
        check_prediction(i - 1);  // Registered lookup of the row before
      end
      drive_row(i);
      #(clock_period / 4);
      check_bit($sformatf("%s pred_miss", row_name[i]), exp_miss[i], pred_miss);
      check_pc($sformatf("%s pred_maddr", row_name[i]), exp_maddr[i], pred_maddr);
    end
    @(negedge clock);
    check_prediction(num_rows - 1);
    get_valid = 1'b0;
    upd_valid = 1'b0;
    $display("Verification passed");
    $finish;
  end

  // Watchdog
  initial begin
    wait (table_ready);
    watchdog_ns = (num_rows * 4 + reset_cycles) * clock_period;
    #(watchdog_ns);
    $display("Timeout: the stimulus table did not finish within %0d ns", watchdog_ns);
    $display("Verification failed");
    $fatal(1, "Watchdog expired");
  end

endmodule
